//--- hw/bridge_ctrl_pkg.sv
// bridge controller package with shared widths, constants and types
`default_nettype none

package bridge_ctrl_pkg;

   // ====================
   // widths
   // ====================
   // tank adc sample, two's complement
   localparam int ADC_W     = 14;
   // four mosfets of the h-bridge
   localparam int N_SW      = 4;
   localparam int DT_W      = 7;
   localparam int STARTUP_W = 8;

   // ====================
   // types
   // ====================
   typedef logic signed [ADC_W-1:0] adc_sample_t;
   // bit 0 is q1, bit 3 is q4
   // legs are {q1,q3} and {q2,q4}
   typedef logic [N_SW-1:0]         sw_vec_t;
   typedef logic [DT_W-1:0]         dt_cnt_t;
   typedef logic [STARTUP_W-1:0]    startup_cnt_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BOOT,
      ST_FORCE,
      ST_RUN
   } startup_state_e;

   // ====================
   // constants
   // ====================
   // full scale codes, neg fs also flags positive over-range
   localparam adc_sample_t ADC_POS_FS = 14'sh1FFF;
   localparam adc_sample_t ADC_NEG_FS = 14'sh2000;
   // shift to offset binary for the dac
   localparam adc_sample_t DAC_OFFSET = 14'sd8191;

   // dead time in clock cycles, suffix is {dsw[3], dsw[2]}
   localparam dt_cnt_t DT_CYC_00 = 7'd80;
   localparam dt_cnt_t DT_CYC_01 = 7'd40;
   localparam dt_cnt_t DT_CYC_10 = 7'd20;
   localparam dt_cnt_t DT_CYC_11 = 7'd60;

   // start-up thresholds
   localparam startup_cnt_t ON_CNT = 8'd10;
   localparam startup_cnt_t VG_CNT = 8'd14;

   // low sides q3 and q4 charge the bootstraps
   localparam sw_vec_t BOOT_PATTERN  = 4'b1100;
   // q1 and q4 force a known tank state
   localparam sw_vec_t FORCE_PATTERN = 4'b1001;

endpackage

`default_nettype wire

//--- hw/adc_sample_cond.sv
// tank adc a conditioning with polarity inversion, over-range clamp and dac copy
`timescale 1ns/1ps
`default_nettype none

module adc_sample_cond (
   input  logic                        i_rst_n,
   input  logic                        ADA_DCO,
   input  bridge_ctrl_pkg::adc_sample_t i_ada_data,
   input  logic                        i_ada_or,
   output bridge_ctrl_pkg::adc_sample_t o_adc_a,
   output bridge_ctrl_pkg::adc_sample_t o_dac_a
);

   // sensing path on the board is inverted
   bridge_ctrl_pkg::adc_sample_t neg_sample;
   bridge_ctrl_pkg::adc_sample_t clamp_sample;

   // two's complement negation
   assign neg_sample = -i_ada_data;

   // over-range clamp
   // raw neg fs is the true signal past positive full scale
   // any other over-range code clamps to the negative rail
   assign clamp_sample = (i_ada_data == bridge_ctrl_pkg::ADC_NEG_FS) ?
                         bridge_ctrl_pkg::ADC_POS_FS :
                         bridge_ctrl_pkg::ADC_NEG_FS;

   // ====================
   // sample register
   // ====================
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_adc_a <= '0;
         o_dac_a <= '0;
      end else begin
         if (i_ada_or) begin
            o_adc_a <= clamp_sample;
         end else begin
            o_adc_a <= neg_sample;
         end
         // dac copy ignores the clamp
         // offset binary with a 14-bit wrap
         o_dac_a <= neg_sample + bridge_ctrl_pkg::DAC_OFFSET;
      end
   end

endmodule

`default_nettype wire

//--- hw/bridge_startup_seq.sv
// h-bridge start-up sequencer for bootstrap charge, forced state and run
`timescale 1ns/1ps
`default_nettype none

module bridge_startup_seq (
   input  logic                            i_rst_n,
   input  logic                            ADA_DCO,
   input  logic                            i_enable,
   output bridge_ctrl_pkg::startup_state_e o_state
);

   // cycles since enable went high
   bridge_ctrl_pkg::startup_cnt_t startup_cnt;

   // ====================
   // start-up counter
   // ====================
   // cleared while disabled
   // stops counting once the bridge is running
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         startup_cnt <= '0;
      end else if (!i_enable) begin
         startup_cnt <= '0;
      end else if (o_state != bridge_ctrl_pkg::ST_RUN) begin
         startup_cnt <= startup_cnt + 1'b1;
      end
   end

   // ====================
   // state register
   // ====================
   // decoded from the count held before this edge
   // boot: low sides on, bootstrap caps charge
   // force: known tank state before handover
   // run: normal switching
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_state <= bridge_ctrl_pkg::ST_IDLE;
      end else if (!i_enable) begin
         // disable drops straight back to idle
         o_state <= bridge_ctrl_pkg::ST_IDLE;
      end else if (startup_cnt <= bridge_ctrl_pkg::ON_CNT) begin
         o_state <= bridge_ctrl_pkg::ST_BOOT;
      end else if (startup_cnt <= bridge_ctrl_pkg::VG_CNT) begin
         o_state <= bridge_ctrl_pkg::ST_FORCE;
      end else begin
         o_state <= bridge_ctrl_pkg::ST_RUN;
      end
   end

endmodule

`default_nettype wire

//--- hw/bridge_gate_drive.sv
// mosfet gate drive with dead time, leg blanking and start-up overrides
`timescale 1ns/1ps
`default_nettype none

module bridge_gate_drive (
   input  logic                            i_rst_n,
   input  logic                            ADA_DCO,
   input  bridge_ctrl_pkg::sw_vec_t        i_sw_cmd,
   input  logic [1:0]                      i_dt_sel,
   input  bridge_ctrl_pkg::startup_state_e i_state,
   output bridge_ctrl_pkg::sw_vec_t        o_q
);

   // selected dead time
   bridge_ctrl_pkg::dt_cnt_t dt_len;
   // per switch high time counters
   bridge_ctrl_pkg::dt_cnt_t dt_cnt [bridge_ctrl_pkg::N_SW];
   // command after rising edge delay
   bridge_ctrl_pkg::sw_vec_t dt_word;
   // dead-timed word with shorted legs blanked
   bridge_ctrl_pkg::sw_vec_t safe_word;
   logic                     leg_short;

   // ====================
   // dead time select
   // ====================
   // i_dt_sel is {dsw[3], dsw[2]}
   always_comb begin
      case (i_dt_sel)
         2'b00:   dt_len = bridge_ctrl_pkg::DT_CYC_00;
         2'b01:   dt_len = bridge_ctrl_pkg::DT_CYC_01;
         2'b10:   dt_len = bridge_ctrl_pkg::DT_CYC_10;
         default: dt_len = bridge_ctrl_pkg::DT_CYC_11;
      endcase
   end

   // ====================
   // dead time insertion
   // ====================
   // a bit turns on only after its command has been high for dt_len
   // cycles and turns off on the first low sample
   // counters saturate at all ones so a switch held on for long
   // never wraps back off
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < bridge_ctrl_pkg::N_SW; i++) begin
            dt_cnt[i] <= '0;
         end
         dt_word <= '0;
      end else begin
         for (int i = 0; i < bridge_ctrl_pkg::N_SW; i++) begin
            if (!i_sw_cmd[i]) begin
               dt_cnt[i]  <= '0;
               dt_word[i] <= 1'b0;
            end else begin
               if (dt_cnt[i] != {bridge_ctrl_pkg::DT_W{1'b1}}) begin
                  dt_cnt[i] <= dt_cnt[i] + 1'b1;
               end
               // compare against the live selection
               dt_word[i] <= (dt_cnt[i] >= dt_len);
            end
         end
      end
   end

   // ====================
   // leg blanking
   // ====================
   // q1/q3 or q2/q4 together would short the supply
   assign leg_short = (dt_word[0] & dt_word[2]) | (dt_word[1] & dt_word[3]);

   // whole bridge off rather than only the offending leg
   assign safe_word = leg_short ? '0 : dt_word;

   // ====================
   // gate output register
   // ====================
   // start-up state overrides the switching command
   always_ff @(posedge ADA_DCO or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_q <= '0;
      end else begin
         unique case (i_state)
            bridge_ctrl_pkg::ST_IDLE:  o_q <= '0;
            // low sides only while bootstraps charge
            bridge_ctrl_pkg::ST_BOOT:  o_q <= bridge_ctrl_pkg::BOOT_PATTERN;
            bridge_ctrl_pkg::ST_FORCE: o_q <= bridge_ctrl_pkg::FORCE_PATTERN;
            bridge_ctrl_pkg::ST_RUN:   o_q <= safe_word;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/bridge_ctrl_top.sv
// resonant tank bridge controller top: adc front end and gate path
`timescale 1ns/1ps
`default_nettype none

module bridge_ctrl_top (
   // reset and tank adc data clock
   input  logic                         i_rst_n,
   input  logic                         ADA_DCO,
   // tank adc a
   input  bridge_ctrl_pkg::adc_sample_t i_ada_data,
   input  logic                         i_ada_or,
   // converter enable switch
   input  logic                         i_enable,
   // switching command from the controller
   input  bridge_ctrl_pkg::sw_vec_t     i_sw_cmd,
   // dead time select, {dsw[3], dsw[2]}
   input  logic [1:0]                   i_dt_sel,
   // conditioned sample and dac copy
   output bridge_ctrl_pkg::adc_sample_t o_adc_a,
   output bridge_ctrl_pkg::adc_sample_t o_dac_a,
   // mosfet gates, bit 0 is q1
   output bridge_ctrl_pkg::sw_vec_t     o_q
);

   // sequencer state into the gate drive
   bridge_ctrl_pkg::startup_state_e startup_state;

   // ====================
   // adc front end
   // ====================
   adc_sample_cond u_adc_sample_cond (
      .i_rst_n    (i_rst_n),
      .ADA_DCO    (ADA_DCO),
      .i_ada_data (i_ada_data),
      .i_ada_or   (i_ada_or),
      .o_adc_a    (o_adc_a),
      .o_dac_a    (o_dac_a)
   );

   // ====================
   // start-up sequencing
   // ====================
   // counts adc clock cycles from enable
   bridge_startup_seq u_bridge_startup_seq (
      .i_rst_n  (i_rst_n),
      .ADA_DCO  (ADA_DCO),
      .i_enable (i_enable),
      .o_state  (startup_state)
   );

   // ====================
   // gate drive
   // ====================
   // enable reaches the gates only through the state
   bridge_gate_drive u_bridge_gate_drive (
      .i_rst_n  (i_rst_n),
      .ADA_DCO  (ADA_DCO),
      .i_sw_cmd (i_sw_cmd),
      .i_dt_sel (i_dt_sel),
      .i_state  (startup_state),
      .o_q      (o_q)
   );

endmodule

`default_nettype wire

//--- testbench/tb_bridge_ctrl_top.sv
// bridge controller testbench for adc conditioning, start-up, dead time and leg safety
`timescale 1ns/1ps
`default_nettype none

module tb_bridge_ctrl_top;

   // ====================
   // dut signals
   // ====================
   logic                         ADA_DCO;
   logic                         i_rst_n;
   bridge_ctrl_pkg::adc_sample_t i_ada_data;
   logic                         i_ada_or;
   logic                         i_enable;
   bridge_ctrl_pkg::sw_vec_t     i_sw_cmd;
   logic [1:0]                   i_dt_sel;
   bridge_ctrl_pkg::adc_sample_t o_adc_a;
   bridge_ctrl_pkg::adc_sample_t o_dac_a;
   bridge_ctrl_pkg::sw_vec_t     o_q;

   // adc inputs as the dut saw them at the last rising edge
   bridge_ctrl_pkg::adc_sample_t cap_data;
   logic                         cap_or;
   logic                         cap_valid;
   logic [31:0]                  rng_state;

   bridge_ctrl_top i_dut (
      .i_rst_n    (i_rst_n),
      .ADA_DCO    (ADA_DCO),
      .i_ada_data (i_ada_data),
      .i_ada_or   (i_ada_or),
      .i_enable   (i_enable),
      .i_sw_cmd   (i_sw_cmd),
      .i_dt_sel   (i_dt_sel),
      .o_adc_a    (o_adc_a),
      .o_dac_a    (o_dac_a),
      .o_q        (o_q)
   );

   // 8 ns adc data clock
   initial begin
      ADA_DCO = 1'b0;
      forever #4 ADA_DCO = ~ADA_DCO;
   end

   // ====================
   // reference functions
   // ====================
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // inverted sample, or the rail it clamps to when over range
   function automatic bridge_ctrl_pkg::adc_sample_t expect_adc(
      input bridge_ctrl_pkg::adc_sample_t raw,
      input logic                         over
   );
      int v;
      v = 0 - int'(raw);
      if (!over) begin
         return v[bridge_ctrl_pkg::ADC_W-1:0];
      end else if (raw == bridge_ctrl_pkg::ADC_NEG_FS) begin
         return bridge_ctrl_pkg::ADC_POS_FS;
      end else begin
         return bridge_ctrl_pkg::ADC_NEG_FS;
      end
   endfunction

   // inverted raw sample shifted to offset binary, 14-bit wrap
   function automatic bridge_ctrl_pkg::adc_sample_t expect_dac(
      input bridge_ctrl_pkg::adc_sample_t raw
   );
      int v;
      v = 8191 - int'(raw);
      return v[bridge_ctrl_pkg::ADC_W-1:0];
   endfunction

   // dsw[3:2] to dead time in cycles
   function automatic int dead_time_cycles(input logic [1:0] sel);
      case (sel)
         2'b00:   return 80;
         2'b01:   return 40;
         2'b10:   return 20;
         default: return 60;
      endcase
   endfunction

   // q1/q3 or q2/q4 on together
   function automatic logic legs_shorted(input bridge_ctrl_pkg::sw_vec_t q);
      return (q[0] & q[2]) | (q[1] & q[3]);
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // ====================
   // comparing process
   // ====================
   always @(posedge ADA_DCO) begin
      cap_data  <= i_ada_data;
      cap_or    <= i_ada_or;
      cap_valid <= i_rst_n;
   end

   // outputs are settled at the falling edge
   always @(negedge ADA_DCO) begin
      if (cap_valid === 1'b1) begin
         assert (o_adc_a === expect_adc(cap_data, cap_or)) else begin
            stop_with_failure($sformatf("Mismatch at %0t: o_adc_a %h expected %h",
               $time, o_adc_a, expect_adc(cap_data, cap_or)));
         end
         assert (o_dac_a === expect_dac(cap_data)) else begin
            stop_with_failure($sformatf("Mismatch at %0t: o_dac_a %h expected %h",
               $time, o_dac_a, expect_dac(cap_data)));
         end
         assert (!legs_shorted(o_q)) else begin
            stop_with_failure($sformatf("Mismatch at %0t: shorted leg on o_q %b",
               $time, o_q));
         end
      end
   end

   // ====================
   // stimulus helpers
   // ====================
   // one clock, then fresh random adc inputs 1 ns after the edge
   task automatic next_cycle();
      logic [31:0] r;
      @(posedge ADA_DCO);
      #1;
      rng_state = xorshift32(rng_state);
      r = rng_state;
      // raw neg fs now and then, to hit the clamp case
      if (r[17:15] == 3'd0) begin
         i_ada_data = bridge_ctrl_pkg::ADC_NEG_FS;
      end else begin
         i_ada_data = r[13:0];
      end
      i_ada_or = (r[20:18] == 3'd0) | ((r[17:15] == 3'd0) & r[21]);
   endtask

   task automatic wait_gate_word(
      input bridge_ctrl_pkg::sw_vec_t want,
      input int                       limit,
      input string                    what
   );
      int n;
      n = 0;
      while (o_q !== want) begin
         if (n >= limit) begin
            stop_with_failure($sformatf("timed out waiting %s, o_q is %b", what, o_q));
         end else begin
            next_cycle();
            n++;
         end
      end
   endtask

   // one switch on, then its leg partner, bridge must blank
   task automatic leg_blank_test(
      input bridge_ctrl_pkg::sw_vec_t first,
      input bridge_ctrl_pkg::sw_vec_t pair
   );
      int lim;
      lim = dead_time_cycles(i_dt_sel) + 3;
      i_sw_cmd = '0;
      wait_gate_word('0, 3, "for the gates to clear");
      i_sw_cmd = first;
      wait_gate_word(first, lim, "for the first switch of the leg");
      i_sw_cmd = pair;
      wait_gate_word('0, lim, "for a shorted leg to blank");
      for (int n = 0; n < 5; n++) begin
         next_cycle();
         assert (o_q === '0) else begin
            stop_with_failure($sformatf("Mismatch at %0t: blanked bridge shows %b",
               $time, o_q));
         end
      end
   endtask

   // ====================
   // test sequence
   // ====================
   initial begin
      int len;
      int bit_idx;
      int n;
      int phase;
      int hold;
      logic seen;
      rng_state  = 32'd38;
      i_rst_n    = 1'b0;
      i_ada_data = '0;
      i_ada_or   = 1'b0;
      i_enable   = 1'b0;
      i_sw_cmd   = '0;
      i_dt_sel   = 2'b00;
      repeat (10) next_cycle();
      // reset values
      assert (o_q === '0 && o_adc_a === '0 && o_dac_a === '0) else begin
         stop_with_failure($sformatf("Mismatch at %0t: reset outputs %b %h %h",
            $time, o_q, o_adc_a, o_dac_a));
      end
      i_rst_n = 1'b1;

      // disabled bridge stays off
      for (n = 0; n < 8; n++) begin
         next_cycle();
         assert (o_q === '0) else begin
            stop_with_failure($sformatf("Mismatch at %0t: o_q %b while disabled",
               $time, o_q));
         end
      end

      // start-up order is idle, boot, force, run
      i_enable = 1'b1;
      phase = 0;
      n = 0;
      while (phase != 3) begin
         next_cycle();
         n++;
         if (n > 20) begin
            stop_with_failure("start-up did not reach run state within 20 cycles");
         end else if (phase <= 1 && o_q === bridge_ctrl_pkg::BOOT_PATTERN) begin
            phase = 1;
         end else if (phase >= 1 && o_q === bridge_ctrl_pkg::FORCE_PATTERN) begin
            phase = 2;
         end else if (phase == 2 && o_q === '0) begin
            phase = 3;
         end else begin
            assert (phase == 0 && o_q === '0) else begin
               stop_with_failure($sformatf("Mismatch at %0t: o_q %b out of start-up order",
                  $time, o_q));
            end
         end
      end

      // dead time for every selection, one random switch each
      for (int sel = 0; sel < 4; sel++) begin
         i_sw_cmd = '0;
         i_dt_sel = sel[1:0];
         next_cycle();
         next_cycle();
         len = dead_time_cycles(sel[1:0]);
         rng_state = xorshift32(rng_state);
         bit_idx = int'(rng_state[1:0]);
         i_sw_cmd[bit_idx] = 1'b1;
         n = 0;
         seen = 1'b0;
         while (!seen) begin
            next_cycle();
            n++;
            if (o_q[bit_idx] === 1'b1) begin
               assert (n > len) else begin
                  stop_with_failure($sformatf("Mismatch at %0t: q%0d on after %0d of %0d",
                     $time, bit_idx + 1, n, len));
               end
               seen = 1'b1;
            end else if (n >= len + 3) begin
               stop_with_failure($sformatf("q%0d did not turn on within %0d cycles",
                  bit_idx + 1, len + 3));
            end
         end
         i_sw_cmd = '0;
         wait_gate_word('0, 2, "for the gate to drop after its command fell");
      end

      // random commands, legs checked on every cycle
      i_dt_sel = 2'b10;
      for (int k = 0; k < 40; k++) begin
         rng_state = xorshift32(rng_state);
         i_sw_cmd = rng_state[3:0];
         hold = int'(rng_state[8:4]);
         for (int h = 0; h <= hold; h++) begin
            next_cycle();
         end
      end
      leg_blank_test(4'b0001, 4'b0101);
      leg_blank_test(4'b0010, 4'b1010);

      // dropping enable turns a running gate off
      i_sw_cmd = 4'b0001;
      wait_gate_word(4'b0001, dead_time_cycles(i_dt_sel) + 3, "for q1 before disable");
      i_enable = 1'b0;
      wait_gate_word('0, 2, "for the gates to clear after disable");

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- bridge_ctrl_top.f
hw/bridge_ctrl_pkg.sv
hw/adc_sample_cond.sv
hw/bridge_startup_seq.sv
hw/bridge_gate_drive.sv
hw/bridge_ctrl_top.sv
testbench/tb_bridge_ctrl_top.sv

//--- Makefile
# Verilator build and run for the bridge controller

VERILATOR  ?= verilator
TB_TOP     ?= tb_bridge_ctrl_top
RTL_TOP    ?= bridge_ctrl_top
FILELIST   ?= bridge_ctrl_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
